// File: Makefile
# Verilator build, run, lint and clean for the light cycle arena

TOP := arena_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f light_cycle.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Done: no errors" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module light_cycle_arena -f light_cycle.f

clean:
	rm -rf obj_dir sim.log

// File: include/arena_settings.svh
// arena geometry, start cells and match length
// shared by the arena package and the RTL blocks
`ifndef ARENA_SETTINGS_SVH
`define ARENA_SETTINGS_SVH

// grid size in cells
`define ARENA_W 16
`define ARENA_H 16

// start cells, both heads on the middle row
`define BLUE_START_X 2
`define BLUE_START_Y 8
`define RED_START_X 13
`define RED_START_Y 8

// crashes that lose the match
`define WIN_TALLY 3

`endif

// File: light_cycle.f
+incdir+include
source/game_pkg.sv
source/arena_pkg.sv
source/game_control.sv
source/cycle_mover.sv
source/trail_map.sv
source/round_score.sv
source/light_cycle_arena.sv
test/clock_gen.sv
test/arena_tb.sv

// File: source/arena_pkg.sv
// arena level types
// grid coordinate and the owner stored in each grid cell
package arena_pkg;

`include "arena_settings.svh"

	// wide enough for either axis of the grid
	localparam int COORD_W = $clog2(`ARENA_W);

	typedef logic [COORD_W-1:0] coord_t;

	// who left a trail in a cell
	typedef enum logic [1:0]
	{
		empty      = 2'd0,
		blue_trail = 2'd1,
		red_trail  = 2'd2
	} cell_t;

endpackage

// File: source/cycle_mover.sv
// cycle mover for both heads
// heading update with reversal filter, one cell per frame tick,
// wall detection and the step pulse for the trail map
`timescale 1ns/1ps

`include "arena_settings.svh"

module cycle_mover
	import game_pkg::*, arena_pkg::*;
(
	input  logic        Clk,
	input  logic        reset,
	input  logic        frame_tick,
	input  game_state_t game_state,
	input  logic        round_restart,
	input  dir_t        blue_dir,
	input  dir_t        red_dir,
	output coord_t      blue_x,
	output coord_t      blue_y,
	output coord_t      red_x,
	output coord_t      red_y,
	output logic        blue_wall,
	output logic        red_wall,
	output logic        step
);

	dir_t blue_heading;
	dir_t red_heading;
	dir_t blue_next;
	dir_t red_next;
	logic blue_blocked;
	logic red_blocked;

	// a request for the opposite heading keeps the current one
	function automatic dir_t pick_dir(input dir_t cur, input dir_t req);
		if (req == dir_t'(cur ^ 2'b10))
			return cur;
		return req;
	endfunction

	function automatic logic hits_wall(input coord_t x, input coord_t y, input dir_t d);
		logic hit;
		unique case (d)
			north: hit = (y == '0);
			south: hit = (y == coord_t'(`ARENA_H - 1));
			east:  hit = (x == coord_t'(`ARENA_W - 1));
			west:  hit = (x == '0);
			default: hit = 1'b0;
		endcase
		return hit;
	endfunction

	function automatic coord_t move_x(input coord_t x, input dir_t d);
		if (d == east)
			return coord_t'(x + 1'b1);
		if (d == west)
			return coord_t'(x - 1'b1);
		return x;
	endfunction

	function automatic coord_t move_y(input coord_t y, input dir_t d);
		if (d == south)
			return coord_t'(y + 1'b1);
		if (d == north)
			return coord_t'(y - 1'b1);
		return y;
	endfunction

	assign blue_next    = pick_dir(blue_heading, blue_dir);
	assign red_next     = pick_dir(red_heading, red_dir);
	assign blue_blocked = hits_wall(blue_x, blue_y, blue_next);
	assign red_blocked  = hits_wall(red_x, red_y, red_next);

	always_ff @(posedge Clk)
	begin
		if (reset || round_restart || game_state == title)
		begin
			blue_x       <= coord_t'(`BLUE_START_X);
			blue_y       <= coord_t'(`BLUE_START_Y);
			red_x        <= coord_t'(`RED_START_X);
			red_y        <= coord_t'(`RED_START_Y);
			blue_heading <= east;
			red_heading  <= west;
			blue_wall    <= 1'b0;
			red_wall     <= 1'b0;
			step         <= 1'b0;
		end
		else
		begin
			step      <= 1'b0;
			blue_wall <= 1'b0;
			red_wall  <= 1'b0;
			if (frame_tick && game_state == play)
			begin
				step         <= 1'b1;
				blue_heading <= blue_next;
				red_heading  <= red_next;
				// a blocked head stays put and reports the wall
				blue_wall    <= blue_blocked;
				red_wall     <= red_blocked;
				if (!blue_blocked)
				begin
					blue_x <= move_x(blue_x, blue_next);
					blue_y <= move_y(blue_y, blue_next);
				end
				if (!red_blocked)
				begin
					red_x <= move_x(red_x, red_next);
					red_y <= move_y(red_y, red_next);
				end
			end
		end
	end

endmodule

// File: source/game_control.sv
// game state controller
// title, play and match over, stepped by start pulses and win flags
`timescale 1ns/1ps

module game_control
	import game_pkg::*;
(
	input  logic        Clk,
	input  logic        reset,
	input  logic        start,
	input  logic        blue_wins,
	input  logic        red_wins,
	output game_state_t game_state
);

	game_state_t next_state;

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			game_state <= title;
		end
		else
		begin
			game_state <= next_state;
		end
	end

	always_comb
	begin
		next_state = game_state;
		unique case (game_state)
			title:
			begin
				if (start)
					next_state = play;
			end
			play:
			begin
				// either flag ends the match
				if (blue_wins || red_wins)
					next_state = match_over;
			end
			match_over:
			begin
				// back to the title screen, blocks clear there
				if (start)
					next_state = title;
			end
			default:
			begin
				next_state = title;
			end
		endcase
	end

endmodule

// File: source/game_pkg.sv
// game level types
// top state of the game and the heading of a cycle
package game_pkg;

	// title screen, round in progress, match decided
	typedef enum logic [1:0]
	{
		title      = 2'd0,
		play       = 2'd1,
		match_over = 2'd2
	} game_state_t;

	// north decreases y, east increases x
	// opposite headings differ in bit 1 only
	typedef enum logic [1:0]
	{
		north = 2'd0,
		east  = 2'd1,
		south = 2'd2,
		west  = 2'd3
	} dir_t;

endpackage

// File: source/light_cycle_arena.sv
// light cycle arena top level
// game controller, cycle mover, trail map and score keeper
`timescale 1ns/1ps

module light_cycle_arena
	import game_pkg::*, arena_pkg::*;
(
	input  logic        Clk,
	input  logic        reset,
	input  logic        frame_tick,
	input  logic        start,
	input  dir_t        blue_dir,
	input  dir_t        red_dir,
	input  coord_t      probe_x,
	input  coord_t      probe_y,
	output game_state_t game_state,
	output coord_t      blue_x,
	output coord_t      blue_y,
	output coord_t      red_x,
	output coord_t      red_y,
	output cell_t       probe_cell,
	output logic [1:0]  crash_count_blue,
	output logic [1:0]  crash_count_red,
	output logic        blue_wins,
	output logic        red_wins,
	output logic        round_restart
);

	logic blue_wall;
	logic red_wall;
	logic step;
	logic blue_crash;
	logic red_crash;

	game_control game_control_i (
		.Clk        (Clk),
		.reset      (reset),
		.start      (start),
		.blue_wins  (blue_wins),
		.red_wins   (red_wins),
		.game_state (game_state)
	);

	cycle_mover cycle_mover_i (
		.Clk           (Clk),
		.reset         (reset),
		.frame_tick    (frame_tick),
		.game_state    (game_state),
		.round_restart (round_restart),
		.blue_dir      (blue_dir),
		.red_dir       (red_dir),
		.blue_x        (blue_x),
		.blue_y        (blue_y),
		.red_x         (red_x),
		.red_y         (red_y),
		.blue_wall     (blue_wall),
		.red_wall      (red_wall),
		.step          (step)
	);

	trail_map trail_map_i (
		.Clk           (Clk),
		.reset         (reset),
		.step          (step),
		.game_state    (game_state),
		.round_restart (round_restart),
		.blue_x        (blue_x),
		.blue_y        (blue_y),
		.red_x         (red_x),
		.red_y         (red_y),
		.blue_wall     (blue_wall),
		.red_wall      (red_wall),
		.blue_crash    (blue_crash),
		.red_crash     (red_crash),
		.probe_x       (probe_x),
		.probe_y       (probe_y),
		.probe_cell    (probe_cell)
	);

	round_score round_score_i (
		.Clk              (Clk),
		.reset            (reset),
		.game_state       (game_state),
		.blue_crash       (blue_crash),
		.red_crash        (red_crash),
		.crash_count_blue (crash_count_blue),
		.crash_count_red  (crash_count_red),
		.blue_wins        (blue_wins),
		.red_wins         (red_wins),
		.round_restart    (round_restart)
	);

endmodule

// File: source/round_score.sv
// crash tallies for both players
// one tally machine per player, the round restart pulse and the win flags
`timescale 1ns/1ps

`include "arena_settings.svh"

module round_score
	import game_pkg::*;
(
	input  logic        Clk,
	input  logic        reset,
	input  game_state_t game_state,
	input  logic        blue_crash,
	input  logic        red_crash,
	output logic [1:0]  crash_count_blue,
	output logic [1:0]  crash_count_red,
	output logic        blue_wins,
	output logic        red_wins,
	output logic        round_restart
);

	// counting waits for a crash, flagged lasts one cycle and asks
	// for a restart, won holds until the title screen
	typedef enum logic [1:0]
	{
		counting = 2'd0,
		flagged  = 2'd1,
		won      = 2'd2
	} tally_state_t;

	localparam int PLAYERS = 2;
	localparam int BLUE = 0;
	localparam int RED = 1;

	tally_state_t     state [PLAYERS];
	logic [1:0]       tally [PLAYERS];
	logic [PLAYERS-1:0] crash_in;
	logic             any_won;
	logic             any_flag;

	assign crash_in[BLUE] = blue_crash;
	assign crash_in[RED]  = red_crash;

	always_ff @(posedge Clk)
	begin
		if (reset || game_state == title)
		begin
			for (int i = 0; i < PLAYERS; i++)
			begin
				state[i] <= counting;
				tally[i] <= 2'd0;
			end
		end
		else
		begin
			// the two machines run side by side, a head-on crash steps both
			for (int i = 0; i < PLAYERS; i++)
			begin
				unique case (state[i])
					counting:
					begin
						if (crash_in[i] && game_state == play)
						begin
							tally[i] <= tally[i] + 2'd1;
							if (tally[i] + 2'd1 == 2'(`WIN_TALLY))
								state[i] <= won;
							else
								state[i] <= flagged;
						end
					end
					flagged:
					begin
						state[i] <= counting;
					end
					won:
					begin
						state[i] <= won;
					end
					default:
					begin
						state[i] <= counting;
					end
				endcase
			end
		end
	end

	assign crash_count_blue = tally[BLUE];
	assign crash_count_red  = tally[RED];

	// a player reaching the tally hands the match to the opponent
	assign red_wins  = (state[BLUE] == won);
	assign blue_wins = (state[RED] == won);

	assign any_won  = red_wins || blue_wins;
	assign any_flag = (state[BLUE] == flagged) || (state[RED] == flagged);

	// no restart once the match is decided
	assign round_restart = any_flag && !any_won;

endmodule

// File: source/trail_map.sv
// trail map of the arena
// one owner per cell, collision checks on each step, trail writes
// and a combinational read port for the renderer
`timescale 1ns/1ps

`include "arena_settings.svh"

module trail_map
	import game_pkg::*, arena_pkg::*;
(
	input  logic        Clk,
	input  logic        reset,
	input  logic        step,
	input  game_state_t game_state,
	input  logic        round_restart,
	input  coord_t      blue_x,
	input  coord_t      blue_y,
	input  coord_t      red_x,
	input  coord_t      red_y,
	input  logic        blue_wall,
	input  logic        red_wall,
	output logic        blue_crash,
	output logic        red_crash,
	input  coord_t      probe_x,
	input  coord_t      probe_y,
	output cell_t       probe_cell
);

	localparam int CELLS = `ARENA_W * `ARENA_H;
	localparam int IDX_W = $clog2(CELLS);

	cell_t grid [CELLS];

	logic [IDX_W-1:0] blue_idx;
	logic [IDX_W-1:0] red_idx;
	logic [IDX_W-1:0] probe_idx;
	logic             same_cell;
	logic             blue_hit;
	logic             red_hit;
	logic             clear;

	// row major, y selects the row
	assign blue_idx  = {blue_y, blue_x};
	assign red_idx   = {red_y, red_x};
	assign probe_idx = {probe_y, probe_x};

	assign same_cell = (blue_idx == red_idx);
	assign blue_hit  = blue_wall || (grid[blue_idx] != empty) || same_cell;
	assign red_hit   = red_wall || (grid[red_idx] != empty) || same_cell;
	assign clear     = round_restart || (game_state == title);

	always_ff @(posedge Clk)
	begin
		if (reset || clear)
		begin
			blue_crash <= 1'b0;
			red_crash  <= 1'b0;
		end
		else
		begin
			blue_crash <= step && blue_hit;
			red_crash  <= step && red_hit;
		end
	end

	// crashed heads leave no mark, so a head-on meeting writes nothing
	always_ff @(posedge Clk)
	begin
		if (clear)
		begin
			for (int i = 0; i < CELLS; i++)
				grid[i] <= empty;
		end
		else if (step)
		begin
			if (!blue_hit)
				grid[blue_idx] <= blue_trail;
			if (!red_hit)
				grid[red_idx] <= red_trail;
		end
	end

	assign probe_cell = grid[probe_idx];

endmodule

// File: test/arena_tb.sv
// testbench for the light cycle arena
// scenario table, reference grid model, LFSR stimulus and checks
`timescale 1ns/1ps

`include "arena_settings.svh"

module arena_tb
	import game_pkg::*, arena_pkg::*;
();

	localparam int ROWS = 5;
	localparam int CELLS = `ARENA_W * `ARENA_H;
	localparam int RANDOM_TICKS = 60;

	logic        Clk;
	logic        reset;
	logic        frame_tick;
	logic        start;
	dir_t        blue_dir;
	dir_t        red_dir;
	coord_t      probe_x;
	coord_t      probe_y;
	game_state_t game_state;
	coord_t      blue_x;
	coord_t      blue_y;
	coord_t      red_x;
	coord_t      red_y;
	cell_t       probe_cell;
	logic [1:0]  crash_count_blue;
	logic [1:0]  crash_count_red;
	logic        blue_wins;
	logic        red_wins;
	logic        round_restart;

	// one row per scenario with headings as N E S W per tick
	// expected tallies and {blue_wins, red_wins} are taken after the last tick
	string      row_name  [ROWS] = '{"straight run", "wall crash", "reversal and trail crash",
		"third crash", "ticks after match"};
	string      blue_seq  [ROWS] = '{"EEEEEE", "NNNNNNNNN", "WEEEEEEEE", "NNNNNNNNN", "EEE"};
	string      red_seq   [ROWS] = '{"WWWWWW", "WWWWWWWWW", "NWEWWWWWS", "WWWWWWWWW", "WWW"};
	int         row_ticks [ROWS] = '{6, 9, 9, 9, 3};
	int         row_blue  [ROWS] = '{1, 2, 2, 3, 3};
	int         row_red   [ROWS] = '{1, 1, 2, 2, 2};
	logic [1:0] row_win   [ROWS] = '{2'b00, 2'b00, 2'b00, 2'b01, 2'b01};

	// reference model of the arena
	game_state_t m_state;
	cell_t       m_grid [CELLS];
	int          m_bx;
	int          m_by;
	int          m_rx;
	int          m_ry;
	dir_t        m_bd;
	dir_t        m_rd;
	int          m_tb;
	int          m_tr;
	logic        m_blue_win;
	logic        m_red_win;
	logic        pending;
	logic        over;

	logic [15:0] lfsr;
	int          errors;
	int          errors_before;
	int          tests_run;
	int          tests_failed;
	string       test_name;

	clock_gen clock_gen_i (
		.Clk   (Clk),
		.reset (reset)
	);

	light_cycle_arena dut_i (
		.Clk              (Clk),
		.reset            (reset),
		.frame_tick       (frame_tick),
		.start            (start),
		.blue_dir         (blue_dir),
		.red_dir          (red_dir),
		.probe_x          (probe_x),
		.probe_y          (probe_y),
		.game_state       (game_state),
		.blue_x           (blue_x),
		.blue_y           (blue_y),
		.red_x            (red_x),
		.red_y            (red_y),
		.probe_cell       (probe_cell),
		.crash_count_blue (crash_count_blue),
		.crash_count_red  (crash_count_red),
		.blue_wins        (blue_wins),
		.red_wins         (red_wins),
		.round_restart    (round_restart)
	);

	// Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	task automatic random_dir(output dir_t d);
		logic [1:0] bits;
		for (int b = 0; b < 2; b++)
		begin
			bits[b] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
		d = dir_t'(bits);
	endtask

	function automatic dir_t char_dir(input byte c);
		case (c)
			"N": return north;
			"E": return east;
			"S": return south;
			default: return west;
		endcase
	endfunction

	function automatic dir_t keep_heading(input dir_t cur, input dir_t req);
		dir_t back;
		case (cur)
			north: back = south;
			south: back = north;
			east:  back = west;
			default: back = east;
		endcase
		return (req == back) ? cur : req;
	endfunction

	function automatic int cell_index(input int x, input int y);
		return y * `ARENA_W + x;
	endfunction

	// one cell in the heading or stay put at the edge of the grid
	task automatic advance(inout int x, inout int y, input dir_t d, output logic wall);
		int nx;
		int ny;
		nx = x;
		ny = y;
		case (d)
			north: ny = y - 1;
			south: ny = y + 1;
			east:  nx = x + 1;
			default: nx = x - 1;
		endcase
		wall = (nx < 0) || (nx >= `ARENA_W) || (ny < 0) || (ny >= `ARENA_H);
		if (!wall)
		begin
			x = nx;
			y = ny;
		end
	endtask

	task automatic clear_round();
		m_bx = `BLUE_START_X;
		m_by = `BLUE_START_Y;
		m_rx = `RED_START_X;
		m_ry = `RED_START_Y;
		m_bd = east;
		m_rd = west;
		for (int i = 0; i < CELLS; i++)
			m_grid[i] = empty;
	endtask

	task automatic enter_title();
		clear_round();
		m_tb = 0;
		m_tr = 0;
		m_blue_win = 1'b0;
		m_red_win = 1'b0;
	endtask

	task automatic predict_step(input dir_t bd, input dir_t rd);
		logic bwall;
		logic rwall;
		logic same;
		logic bhit;
		logic rhit;
		pending = 1'b0;
		over = 1'b0;
		if (m_state != play)
			return;
		m_bd = keep_heading(m_bd, bd);
		m_rd = keep_heading(m_rd, rd);
		advance(m_bx, m_by, m_bd, bwall);
		advance(m_rx, m_ry, m_rd, rwall);
		same = (m_bx == m_rx) && (m_by == m_ry);
		bhit = bwall || (m_grid[cell_index(m_bx, m_by)] != empty) || same;
		rhit = rwall || (m_grid[cell_index(m_rx, m_ry)] != empty) || same;
		if (!bhit)
			m_grid[cell_index(m_bx, m_by)] = blue_trail;
		if (!rhit)
			m_grid[cell_index(m_rx, m_ry)] = red_trail;
		if (bhit)
			m_tb++;
		if (rhit)
			m_tr++;
		// a full tally hands the match to the other player
		if (m_tb == `WIN_TALLY)
			m_red_win = 1'b1;
		if (m_tr == `WIN_TALLY)
			m_blue_win = 1'b1;
		over = m_blue_win || m_red_win;
		pending = (bhit || rhit) && !over;
	endtask

	task automatic note_mismatch(input string what, input int got, input int exp);
		errors++;
		$display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
	endtask

	task automatic check_heads();
		if (int'(blue_x) != m_bx)
			note_mismatch("blue_x", int'(blue_x), m_bx);
		if (int'(blue_y) != m_by)
			note_mismatch("blue_y", int'(blue_y), m_by);
		if (int'(red_x) != m_rx)
			note_mismatch("red_x", int'(red_x), m_rx);
		if (int'(red_y) != m_ry)
			note_mismatch("red_y", int'(red_y), m_ry);
	endtask

	task automatic check_status();
		if (game_state != m_state)
			note_mismatch("game_state", int'(game_state), int'(m_state));
		if (int'(crash_count_blue) != m_tb)
			note_mismatch("crash_count_blue", int'(crash_count_blue), m_tb);
		if (int'(crash_count_red) != m_tr)
			note_mismatch("crash_count_red", int'(crash_count_red), m_tr);
		if (blue_wins != m_blue_win)
			note_mismatch("blue_wins", int'(blue_wins), int'(m_blue_win));
		if (red_wins != m_red_win)
			note_mismatch("red_wins", int'(red_wins), int'(m_red_win));
	endtask

	task automatic check_map();
		for (int y = 0; y < `ARENA_H; y++)
		begin
			for (int x = 0; x < `ARENA_W; x++)
			begin
				@(posedge Clk);
				probe_x <= coord_t'(x);
				probe_y <= coord_t'(y);
				@(negedge Clk);
				if (probe_cell != m_grid[cell_index(x, y)])
					note_mismatch($sformatf("cell (%0d,%0d)", x, y), int'(probe_cell),
						int'(m_grid[cell_index(x, y)]));
			end
		end
	endtask

	// one frame checked on each edge from T+1 to T+6
	task automatic run_tick(input dir_t bd, input dir_t rd);
		int restarts;
		restarts = 0;
		@(posedge Clk);
		blue_dir   <= bd;
		red_dir    <= rd;
		frame_tick <= 1'b1;
		@(posedge Clk);
		frame_tick <= 1'b0;
		predict_step(bd, rd);
		for (int k = 1; k <= 6; k++)
		begin
			@(negedge Clk);
			if (k == 4 && pending)
				clear_round();
			if (k == 4 && over)
				m_state = match_over;
			if (round_restart)
			begin
				restarts++;
				if (k != 3)
					note_mismatch("edge of round_restart after the tick", k, 3);
			end
			check_heads();
			if (k >= 3)
				check_status();
		end
		if (restarts != (pending ? 1 : 0))
			note_mismatch("round_restart pulses", restarts, pending ? 1 : 0);
		check_map();
	endtask

	task automatic press_start(input game_state_t target);
		int waited;
		waited = 0;
		@(posedge Clk);
		start <= 1'b1;
		@(posedge Clk);
		start <= 1'b0;
		@(negedge Clk);
		while (game_state != target && waited < 10)
		begin
			@(negedge Clk);
			waited++;
		end
		if (game_state != target)
		begin
			errors++;
			$display("game state did not change after a start pulse within 10 cycles");
		end
		m_state = target;
		if (target == title)
			enter_title();
		// title clears the blocks one edge later
		repeat (2) @(negedge Clk);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_before = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == errors_before)
		begin
			$display("test %s: passed", test_name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: %0d checks failed", test_name, errors - errors_before);
		end
	endtask

	initial
	begin
		#2_000_000;
		$display("the simulation ran past its time limit");
		$display("Done: errors found");
		$finish;
	end

	initial
	begin
		dir_t  bd;
		dir_t  rd;
		string bs;
		string rs;
		int    waited;
		frame_tick = 1'b0;
		start = 1'b0;
		blue_dir = east;
		red_dir = west;
		probe_x = '0;
		probe_y = '0;
		lfsr = 16'd38613;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		m_state = title;
		enter_title();

		begin_test("reset and title");
		waited = 0;
		@(posedge Clk);
		@(negedge Clk);
		while (reset && waited < 20)
		begin
			@(negedge Clk);
			waited++;
		end
		if (reset)
		begin
			errors++;
			$display("reset was never released");
		end
		check_status();
		check_heads();
		check_map();
		run_tick(north, south);
		run_tick(west, east);
		end_test();

		press_start(play);
		for (int r = 0; r < ROWS; r++)
		begin
			begin_test(row_name[r]);
			bs = blue_seq[r];
			rs = red_seq[r];
			for (int t = 0; t < row_ticks[r]; t++)
				run_tick(char_dir(bs[t]), char_dir(rs[t]));
			if (int'(crash_count_blue) != row_blue[r])
				note_mismatch("blue tally at row end", int'(crash_count_blue), row_blue[r]);
			if (int'(crash_count_red) != row_red[r])
				note_mismatch("red tally at row end", int'(crash_count_red), row_red[r]);
			if ({blue_wins, red_wins} != row_win[r])
				note_mismatch("win flags at row end", int'({blue_wins, red_wins}),
					int'(row_win[r]));
			end_test();
		end

		begin_test("start after match");
		press_start(title);
		check_status();
		check_heads();
		check_map();
		end_test();

		begin_test("random play");
		for (int t = 0; t < RANDOM_TICKS; t++)
		begin
			if (m_state == match_over)
				press_start(title);
			if (m_state == title)
				press_start(play);
			random_dir(bd);
			random_dir(rd);
			run_tick(bd, rd);
		end
		end_test();

		$display("tests run: %0d, tests failed: %0d, failed checks: %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: test/clock_gen.sv
// clock and reset source for the testbench
// 4 ns clock, reset held high for the first 4 rising edges
`timescale 1ns/1ps

module clock_gen
(
	output logic Clk,
	output logic reset
);

	initial
	begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (4) @(posedge Clk);
		reset <= 1'b0;
	end

endmodule
